// File: hw/bf_pkg.sv
// Widths and encodings shared by the core and its monitor; begin and end decode as no-op
package bf_pkg;

    // ------------------------------
    // Widths with a meaning
    // ------------------------------
    typedef logic [15:0] pc_t;   // Instruction nibble address
    typedef logic [14:0] ptr_t;  // Data byte address
    typedef logic [7:0]  cell_t; // Data or I/O byte
    typedef logic [3:0]  code_t; // Opcode nibble

    // Tape language opcodes
    typedef enum code_t {
        op_ptr_inc  = 4'h0,
        op_ptr_dec  = 4'h1,
        op_cell_inc = 4'h2,
        op_cell_dec = 4'h3,
        op_out      = 4'h4,
        op_in       = 4'h5,
        op_begin    = 4'h6,
        op_end      = 4'h7,
        op_restart  = 4'h8,
        op_nop      = 4'hf
    } opcode_e;

    // ALU result select
    typedef enum logic [1:0] {
        alu_zero = 2'd0,
        alu_pass = 2'd1,
        alu_inc  = 2'd2,
        alu_dec  = 2'd3
    } alu_func_e;

    // Sequencer states
    typedef enum logic [2:0] {
        init_start = 3'd0,
        init_clear = 3'd1,
        decode     = 3'd2,
        inc_wb     = 3'd3,
        dec_wb     = 3'd4,
        out_wb     = 3'd5,
        in_wb      = 3'd6
    } state_e;

    // ------------------------------
    // Strobes from the sequencer
    // ------------------------------
    typedef struct packed {
        logic fetch;
        logic pc_inc;
        logic pc_clr;
        logic ptr_inc;
        logic ptr_dec;
        logic ptr_clr;
        logic mem_read;
        logic mem_write;
        logic io_read;
        logic io_write;
    } ctrl_t;

endpackage

// File: hw/read_capture.sv
// Read data is taken on the first ready cycle after the request and held until the next read
`timescale 1ns/1ps

module read_capture
    import bf_pkg::*;
(
    input  logic  CLK,
    input  logic  RES,
    input  logic  if_rdy,
    input  logic  dm_rdy,
    input  logic  io_rdy,
    input  cell_t dm_rdata,
    input  cell_t io_rdata,
    input  logic  dm_req,
    input  logic  dm_write,
    input  logic  io_req,
    input  logic  io_write,
    output logic  slot,
    output cell_t mem_byte,
    output cell_t io_byte
);

    logic  mem_dph;
    logic  io_dph;
    cell_t mem_hold;
    cell_t io_hold;

    // Core moves only while every port is ready
    assign slot = if_rdy & dm_rdy & io_rdy;

    // ------------------------------
    // Memory read data phase
    // ------------------------------
    always_ff @(posedge CLK or posedge RES)
    begin
        if (RES)
            mem_dph <= 1'b0;
        else if (dm_req & ~dm_write & dm_rdy)
            mem_dph <= 1'b1;
        else if (dm_rdy)
            mem_dph <= 1'b0;
    end

    always_ff @(posedge CLK)
    begin
        if (mem_dph & dm_rdy)
            mem_hold <= dm_rdata;
    end

    // Pass through in the arrival cycle
    assign mem_byte = (mem_dph & dm_rdy) ? dm_rdata : mem_hold;

    // ------------------------------
    // I/O read data phase
    // ------------------------------
    always_ff @(posedge CLK or posedge RES)
    begin
        if (RES)
            io_dph <= 1'b0;
        else if (io_req & ~io_write & io_rdy)
            io_dph <= 1'b1;
        else if (io_rdy)
            io_dph <= 1'b0;
    end

    always_ff @(posedge CLK)
    begin
        if (io_dph & io_rdy)
            io_hold <= io_rdata;
    end

    assign io_byte = (io_dph & io_rdy) ? io_rdata : io_hold;

endmodule

// File: hw/fetch_unit.sv
// Program memory must return the opcode on the first if_rdy cycle after an accepted request
`timescale 1ns/1ps

module fetch_unit
    import bf_pkg::*;
(
    input  logic  CLK,
    input  logic  RES,
    input  logic  slot,
    input  logic  if_rdy,
    input  ctrl_t ctrl,
    input  code_t if_code,
    output logic  if_req,
    output pc_t   if_addr,
    output code_t opcode
);

    pc_t   pc;
    logic  if_dph;
    code_t code_hold;

    // Request only in a slot cycle
    assign if_req  = ctrl.fetch & slot;
    assign if_addr = pc;

    // ------------------------------
    // Program counter
    // ------------------------------
    always_ff @(posedge CLK or posedge RES)
    begin
        if (RES)
            pc <= '0;
        else if (slot)
        begin
            // Clear wins over increment
            if (ctrl.pc_clr)
                pc <= '0;
            else if (ctrl.pc_inc)
                pc <= pc + pc_t'(1);
        end
    end

    // Data phase pending after an accepted fetch
    always_ff @(posedge CLK or posedge RES)
    begin
        if (RES)
            if_dph <= 1'b0;
        else if (if_req & if_rdy)
            if_dph <= 1'b1;
        else if (if_rdy)
            if_dph <= 1'b0;
    end

    // Last opcode seen
    always_ff @(posedge CLK or posedge RES)
    begin
        if (RES)
            code_hold <= op_nop;
        else if (if_dph & if_rdy)
            code_hold <= if_code;
    end

    // Fresh opcode in its data cycle, held one otherwise
    assign opcode = (if_dph & if_rdy) ? if_code : code_hold;

endmodule

// File: hw/sequencer.sv
// One opcode per decode pass with no loop support; begin, end and unknown codes only fetch
`timescale 1ns/1ps

module sequencer
    import bf_pkg::*;
(
    input  logic  CLK,
    input  logic  RES,
    input  logic  slot,
    input  code_t opcode,
    input  logic  clear_done,
    input  cell_t mem_byte,
    input  cell_t io_byte,
    output ctrl_t ctrl,
    output cell_t wdata
);

    state_e    state;
    state_e    state_nxt;
    alu_func_e alu_func;
    cell_t     alu_in;

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge CLK or posedge RES)
    begin
        if (RES)
            state <= init_start;
        else if (slot)
            state <= state_nxt;
    end

    // ------------------------------
    // Next state and strobes
    // ------------------------------
    always_comb
    begin
        state_nxt = state;
        ctrl      = '0;
        alu_func  = alu_zero;
        case (state)
            init_start:
            begin
                // Rewind both counters
                ctrl.pc_clr  = 1'b1;
                ctrl.ptr_clr = 1'b1;
                state_nxt    = init_clear;
            end
            init_clear:
            begin
                // Zero write at the pointer
                ctrl.mem_write = 1'b1;
                alu_func       = alu_zero;
                if (clear_done)
                begin
                    // Last cell, start fetching from 0
                    ctrl.ptr_clr = 1'b1;
                    ctrl.fetch   = 1'b1;
                    ctrl.pc_inc  = 1'b1;
                    state_nxt    = decode;
                end
                else
                    ctrl.ptr_inc = 1'b1;
            end
            decode:
            begin
                case (opcode)
                    op_ptr_inc, op_ptr_dec:
                    begin
                        ctrl.ptr_inc = (opcode == op_ptr_inc);
                        ctrl.ptr_dec = (opcode == op_ptr_dec);
                        ctrl.fetch   = 1'b1;
                        ctrl.pc_inc  = 1'b1;
                    end
                    op_cell_inc:
                    begin
                        ctrl.mem_read = 1'b1;
                        state_nxt     = inc_wb;
                    end
                    op_cell_dec:
                    begin
                        ctrl.mem_read = 1'b1;
                        state_nxt     = dec_wb;
                    end
                    op_out:
                    begin
                        ctrl.mem_read = 1'b1;
                        state_nxt     = out_wb;
                    end
                    op_in:
                    begin
                        ctrl.io_read = 1'b1;
                        state_nxt    = in_wb;
                    end
                    op_restart:
                        state_nxt = init_start;
                    default:
                    begin
                        // No-op, begin, end and unknown codes
                        ctrl.fetch  = 1'b1;
                        ctrl.pc_inc = 1'b1;
                    end
                endcase
            end
            inc_wb, dec_wb, out_wb, in_wb:
            begin
                // Write back and fetch the next opcode
                ctrl.fetch  = 1'b1;
                ctrl.pc_inc = 1'b1;
                state_nxt   = decode;
                case (state)
                    inc_wb:  alu_func = alu_inc;
                    dec_wb:  alu_func = alu_dec;
                    default: alu_func = alu_pass;
                endcase
                // Output goes to I/O, everything else back to the cell
                ctrl.io_write  = (state == out_wb);
                ctrl.mem_write = (state != out_wb);
            end
            default:
                state_nxt = init_start;
        endcase
    end

    // ------------------------------
    // ALU
    // ------------------------------
    // Input byte only in the input write-back
    assign alu_in = (state == in_wb) ? io_byte : mem_byte;

    always_comb
    begin
        case (alu_func)
            alu_pass: wdata = alu_in;
            alu_inc:  wdata = alu_in + cell_t'(1);
            alu_dec:  wdata = alu_in - cell_t'(1);
            default:  wdata = '0;
        endcase
    end

endmodule

// File: hw/data_port.sv
// Pointer wraps at 15 bits; the clear stops at CLEAR_LAST and cells above it keep old data
`timescale 1ns/1ps

module data_port
    import bf_pkg::*;
#(
    parameter ptr_t CLEAR_LAST = 15'h7fff
)
(
    input  logic  CLK,
    input  logic  RES,
    input  logic  slot,
    input  ctrl_t ctrl,
    input  cell_t wdata,
    output logic  clear_done,
    output logic  dm_req,
    output logic  dm_write,
    output ptr_t  dm_addr,
    output cell_t dm_wdata,
    output logic  io_req,
    output logic  io_write,
    output cell_t io_wdata
);

    ptr_t ptr;

    // ------------------------------
    // Data pointer
    // ------------------------------
    always_ff @(posedge CLK or posedge RES)
    begin
        if (RES)
            ptr <= '0;
        else if (slot)
        begin
            if (ctrl.ptr_clr)
                ptr <= '0;
            else if (ctrl.ptr_inc)
                ptr <= ptr + ptr_t'(1);
            else if (ctrl.ptr_dec)
                ptr <= ptr - ptr_t'(1);
        end
    end

    // Last cell of the memory clear
    assign clear_done = (ptr == CLEAR_LAST);

    // ------------------------------
    // Request drivers
    // ------------------------------
    // Write flags gated too, so they never show without a request
    assign dm_req   = (ctrl.mem_read | ctrl.mem_write) & slot;
    assign dm_write = ctrl.mem_write & slot;
    assign dm_addr  = ptr;
    assign dm_wdata = wdata;

    assign io_req   = (ctrl.io_read | ctrl.io_write) & slot;
    assign io_write = ctrl.io_write & slot;
    // Same ALU byte on both buses
    assign io_wdata = wdata;

endmodule

// File: hw/bf_core.sv
// Nothing advances unless all three ready inputs are high; set CLEAR_LAST low to shorten the clear
`timescale 1ns/1ps

module bf_core
    import bf_pkg::*;
#(
    parameter ptr_t CLEAR_LAST = 15'h7fff
)
(
    input  logic  CLK,
    input  logic  RES,
    // Instruction fetch
    output logic  if_req,
    output pc_t   if_addr,
    input  code_t if_code,
    input  logic  if_rdy,
    // Data memory
    output logic  dm_req,
    output logic  dm_write,
    output ptr_t  dm_addr,
    output cell_t dm_wdata,
    input  cell_t dm_rdata,
    input  logic  dm_rdy,
    // I/O
    output logic  io_req,
    output logic  io_write,
    output cell_t io_wdata,
    input  cell_t io_rdata,
    input  logic  io_rdy
);

    logic  slot;
    ctrl_t ctrl;
    cell_t wdata;
    cell_t mem_byte;
    cell_t io_byte;
    code_t opcode;
    logic  clear_done;

    // ------------------------------
    // Input side
    // ------------------------------
    read_capture read_capture_i (
        .CLK      (CLK),
        .RES      (RES),
        .if_rdy   (if_rdy),
        .dm_rdy   (dm_rdy),
        .io_rdy   (io_rdy),
        .dm_rdata (dm_rdata),
        .io_rdata (io_rdata),
        .dm_req   (dm_req),
        .dm_write (dm_write),
        .io_req   (io_req),
        .io_write (io_write),
        .slot     (slot),
        .mem_byte (mem_byte),
        .io_byte  (io_byte)
    );

    fetch_unit fetch_unit_i (
        .CLK     (CLK),
        .RES     (RES),
        .slot    (slot),
        .if_rdy  (if_rdy),
        .ctrl    (ctrl),
        .if_code (if_code),
        .if_req  (if_req),
        .if_addr (if_addr),
        .opcode  (opcode)
    );

    // ------------------------------
    // Processing
    // ------------------------------
    sequencer sequencer_i (
        .CLK        (CLK),
        .RES        (RES),
        .slot       (slot),
        .opcode     (opcode),
        .clear_done (clear_done),
        .mem_byte   (mem_byte),
        .io_byte    (io_byte),
        .ctrl       (ctrl),
        .wdata      (wdata)
    );

    // Output side
    data_port #(
        .CLEAR_LAST (CLEAR_LAST)
    ) data_port_i (
        .CLK        (CLK),
        .RES        (RES),
        .slot       (slot),
        .ctrl       (ctrl),
        .wdata      (wdata),
        .clear_done (clear_done),
        .dm_req     (dm_req),
        .dm_write   (dm_write),
        .dm_addr    (dm_addr),
        .dm_wdata   (dm_wdata),
        .io_req     (io_req),
        .io_write   (io_write),
        .io_wdata   (io_wdata)
    );

endmodule

// File: bench/bf_core_checker.sv
// Port protocol assertions; requests may only show in cycles where every ready is high
`timescale 1ns/1ps

module bf_core_checker (
    input logic CLK,
    input logic RES,
    input logic if_req,
    input logic dm_req,
    input logic io_req,
    input logic dm_write,
    input logic io_write,
    input logic if_rdy,
    input logic dm_rdy,
    input logic io_rdy
);

    logic all_rdy;
    // Failed assertion count, read by the testbench top
    int   fail_cnt;

    assign all_rdy = if_rdy & dm_rdy & io_rdy;

    // ------------------------------
    // Back-pressure gating
    // ------------------------------
    a_req_gated: assert property (@(posedge CLK) disable iff (RES)
        (if_req | dm_req | io_req) |-> all_rdy)
        else
        begin
            $error("request raised while a ready input was low");
            fail_cnt++;
        end

    // Write flags need their own request
    a_dm_write: assert property (@(posedge CLK) dm_write |-> dm_req)
        else
        begin
            $error("dm_write without dm_req");
            fail_cnt++;
        end
    a_io_write: assert property (@(posedge CLK) io_write |-> io_req)
        else
        begin
            $error("io_write without io_req");
            fail_cnt++;
        end

    // First cycle out of reset is init_start, no fetch
    a_reset_fetch: assert property (@(posedge CLK) $fell(RES) |-> !if_req)
        else
        begin
            $error("if_req high right after reset");
            fail_cnt++;
        end

endmodule

bind bf_core bf_core_checker checker_i (.*);

// File: bench/bf_core_monitor.sv
// Expects each clear to write zeros from cell 0 up to CLEAR_LAST before a fetch of address 0
`timescale 1ns/1ps

module bf_core_monitor
    import bf_pkg::*;
#(
    parameter ptr_t CLEAR_LAST = 15'h7fff
)
(
    input  logic        CLK,
    input  logic        if_req, if_rdy, dm_req, dm_write, io_req, io_write,
    input  pc_t         if_addr,
    input  code_t       if_code,
    input  ptr_t        dm_addr,
    input  cell_t       dm_wdata, io_wdata,
    input  logic        test_start, test_end, addr_chk,
    input  int          test_num,
    input  logic [31:0] exp_out,
    input  logic [2:0]  exp_n,
    input  logic [1:0]  exp_clears,
    input  ptr_t        exp_addr,
    output int          n_pass, n_fail
);

    int   n_out, n_clears, errs, passes, fails;
    ptr_t cidx;
    logic clearing, dph, first_seen;

    initial
    begin
        passes = 0;
        fails = 0;
    end
    assign n_pass = passes;
    assign n_fail = fails;

    always @(posedge CLK)
    begin
        if (test_start)
        begin
            n_out = 0;
            n_clears = 0;
            errs = 0;
            cidx = '0;
            clearing = 1'b1;
            dph = 1'b0;
            first_seen = 1'b0;
        end
        else
        begin
            // ------------------------------
            // Memory writes, clear or program
            // ------------------------------
            if (dm_req & dm_write)
            begin
                if (clearing)
                begin
                    if (dm_addr != cidx || dm_wdata != 8'h00)
                    begin
                        $display("mismatch dm_addr/dm_wdata: expected %h/00, got %h/%h",
                                 cidx, dm_addr, dm_wdata);
                        errs++;
                    end
                    cidx = cidx + ptr_t'(1);
                end
                else if (addr_chk && !first_seen)
                begin
                    first_seen = 1'b1;
                    if (dm_addr != exp_addr)
                    begin
                        $display("mismatch dm_addr: expected %h, got %h", exp_addr, dm_addr);
                        errs++;
                    end
                end
            end
            // Restart opcode arriving starts a new clear
            if (dph && if_rdy && if_code == op_restart)
            begin
                clearing = 1'b1;
                cidx = '0;
            end
            if (if_req & if_rdy)
            begin
                if (clearing)
                begin
                    if (if_addr != '0)
                    begin
                        $display("first fetch after a clear was not at address 0");
                        errs++;
                    end
                    if (cidx != CLEAR_LAST + ptr_t'(1))
                    begin
                        $display("clear wrote %0d cells before the fetch", cidx);
                        errs++;
                    end
                    n_clears++;
                    clearing = 1'b0;
                end
                dph = 1'b1;
            end
            else if (if_rdy)
                dph = 1'b0;
            // Output writes in order
            if (io_req & io_write)
            begin
                if (n_out >= int'(exp_n))
                begin
                    $display("extra output write of %h", io_wdata);
                    errs++;
                end
                else if (io_wdata != exp_out[8 * n_out +: 8])
                begin
                    $display("mismatch io_wdata: expected %h, got %h",
                             exp_out[8 * n_out +: 8], io_wdata);
                    errs++;
                end
                n_out++;
            end
            if (test_end)
            begin
                if (n_out < int'(exp_n))
                begin
                    $display("only %0d of %0d output writes seen", n_out, exp_n);
                    errs++;
                end
                if (n_clears != int'(exp_clears))
                begin
                    $display("saw %0d memory clears, expected %0d", n_clears, exp_clears);
                    errs++;
                end
                if (addr_chk && !first_seen)
                begin
                    $display("no program write to memory was seen");
                    errs++;
                end
                if (errs == 0)
                begin
                    $display("test %0d: ok", test_num);
                    passes++;
                end
                else
                begin
                    $display("test %0d: %0d errors", test_num, errs);
                    fails++;
                end
            end
        end
    end

endmodule

// File: bench/tb_bf_core.sv
// Runs each table row from reset with CLEAR_LAST at 31; a restart nibble is served once per row
`timescale 1ns/1ps

module tb_bf_core
    import bf_pkg::*;
();

    localparam ptr_t CLEAR_LAST = 15'd31;
    localparam int   N_ROWS     = 8;

    // One test row; nibble i of prog and byte i of din/dout sit at the low end
    typedef struct packed {
        logic        stall;
        logic [4:0]  len;
        logic [63:0] prog;
        logic [31:0] din;
        logic [2:0]  din_n;
        logic [31:0] dout;
        logic [2:0]  dout_n;
        logic [1:0]  clears;
        logic        addr_chk;
        ptr_t        first_addr;
    } row_t;

    logic  CLK;
    logic  RES;
    logic  if_req, if_rdy, dm_req, dm_write, dm_rdy, io_req, io_write, io_rdy;
    pc_t   if_addr;
    code_t if_code;
    ptr_t  dm_addr;
    cell_t dm_wdata, dm_rdata, io_wdata, io_rdata;

    row_t        rows [N_ROWS];
    code_t       prog [64];
    cell_t       dmem [32768];
    cell_t       in_q [$];
    logic        stall_en;
    logic [31:0] rnd_state;
    int          cycles;
    int          limit;

    // Monitor interface
    logic        test_start, test_end, addr_chk;
    logic [31:0] exp_out;
    logic [2:0]  exp_n;
    logic [1:0]  exp_clears;
    ptr_t        exp_addr;
    int          test_num, n_pass, n_fail;

    bf_core #(.CLEAR_LAST(CLEAR_LAST)) bf_core_i (.*);

    bf_core_monitor #(.CLEAR_LAST(CLEAR_LAST)) monitor_i (
        .CLK(CLK), .if_req(if_req), .if_addr(if_addr), .if_code(if_code), .if_rdy(if_rdy),
        .dm_req(dm_req), .dm_write(dm_write), .dm_addr(dm_addr), .dm_wdata(dm_wdata),
        .io_req(io_req), .io_write(io_write), .io_wdata(io_wdata),
        .test_start(test_start), .test_end(test_end), .test_num(test_num),
        .exp_out(exp_out), .exp_n(exp_n), .exp_clears(exp_clears),
        .addr_chk(addr_chk), .exp_addr(exp_addr), .n_pass(n_pass), .n_fail(n_fail)
    );

    // Linear congruential generator
    function automatic logic [31:0] next_rand();
        rnd_state = rnd_state * 32'd1103515245 + 32'd12345;
        return rnd_state;
    endfunction

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // ------------------------------
    // Port models, one-cycle data phase
    // ------------------------------
    always @(posedge CLK)
    begin
        if (if_req)
        begin
            if_code <= prog[if_addr[5:0]];
            // Restart only once, otherwise the program never ends
            if (prog[if_addr[5:0]] == op_restart)
                prog[if_addr[5:0]] <= op_nop;
        end
        if (dm_req & dm_write)
            dmem[dm_addr] <= dm_wdata;
        else if (dm_req)
            dm_rdata <= dmem[dm_addr];
        if (io_req & ~io_write)
            io_rdata <= (in_q.size() > 0) ? in_q.pop_front() : 8'h00;
    end

    // Ready stalls, about one low cycle in four per port
    always @(posedge CLK)
    begin
        if (stall_en)
        begin
            if_rdy <= (next_rand() & 32'h30000) != 32'h0;
            dm_rdy <= (next_rand() & 32'h30000) != 32'h0;
            io_rdy <= (next_rand() & 32'h30000) != 32'h0;
        end
        else
        begin
            if_rdy <= 1'b1;
            dm_rdy <= 1'b1;
            io_rdy <= 1'b1;
        end
    end

    // Run limit
    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= limit)
        begin
            $display("timeout after %0d cycles, the program never reached its end", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // ------------------------------
    // Test table and sequence
    // ------------------------------
    initial
    begin
        RES = 1'b1;
        if_rdy = 1'b1;
        dm_rdy = 1'b1;
        io_rdy = 1'b1;
        if_code = op_nop;
        dm_rdata = '0;
        io_rdata = '0;
        stall_en = 1'b0;
        rnd_state = 32'h83c4;
        cycles = 0;
        test_start = 1'b0;
        test_end = 1'b0;
        test_num = 0;
        exp_out = '0;
        exp_n = '0;
        exp_clears = '0;
        addr_chk = 1'b0;
        exp_addr = '0;
        // Arithmetic: +++ . -- . -- .
        rows[0] = '{1'b0, 5'd10, 64'h4334334222, 32'h0, 3'd0, 32'h00ff0103, 3'd3,
                    2'd1, 1'b0, 15'd0};
        // Pointer: > + . < < .
        rows[1] = '{1'b0, 5'd6, 64'h411420, 32'h0, 3'd0, 32'h0001, 3'd2, 2'd1, 1'b1, 15'd1};
        // Input echo plus one, four times
        rows[2] = '{1'b0, 5'd12, 64'h425425425425, 32'h7fff4100, 3'd4, 32'h80004201, 3'd4,
                    2'd1, 1'b0, 15'd0};
        // + . begin end nop restart .
        rows[3] = '{1'b0, 5'd7, 64'h48f7642, 32'h0, 3'd0, 32'h010101, 3'd3, 2'd2, 1'b0, 15'd0};
        for (int i = 0; i < 4; i++)
        begin
            rows[i + 4] = rows[i];
            rows[i + 4].stall = 1'b1;
        end
        limit = 0;
        for (int i = 0; i < N_ROWS; i++)
            limit += 4 * (int'(CLEAR_LAST) + 4 + 2 * int'(rows[i].len) + 10);

        for (int t = 0; t < N_ROWS; t++)
        begin
            RES <= 1'b1;
            // Model memories loaded while the core is held in reset
            for (int i = 0; i < 64; i++)
                prog[i] = op_nop;
            for (int i = 0; i < int'(rows[t].len); i++)
                prog[i] = rows[t].prog[4 * i +: 4];
            for (int a = 0; a < 32768; a++)
                dmem[a] = 8'h00;
            in_q.delete();
            for (int i = 0; i < int'(rows[t].din_n); i++)
                in_q.push_back(rows[t].din[8 * i +: 8]);
            test_num <= t;
            exp_out <= rows[t].dout;
            exp_n <= rows[t].dout_n;
            exp_clears <= rows[t].clears;
            addr_chk <= rows[t].addr_chk;
            exp_addr <= rows[t].first_addr;
            repeat (9) @(posedge CLK);
            test_start <= 1'b1;
            @(posedge CLK);
            test_start <= 1'b0;
            RES <= 1'b0;
            stall_en <= rows[t].stall;
            // Fetch of the address past the program ends the test
            do
                @(posedge CLK);
            while (!(if_req && if_rdy && if_addr == pc_t'(rows[t].len)));
            stall_en <= 1'b0;
            test_end <= 1'b1;
            @(posedge CLK);
            test_end <= 1'b0;
        end
        @(posedge CLK);
        $display("Tests: %0d passed, %0d failed, %0d assertion failures",
                 n_pass, n_fail, bf_core_i.checker_i.fail_cnt);
        if (n_fail == 0 && n_pass == N_ROWS && bf_core_i.checker_i.fail_cnt == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: bf_core.f
hw/bf_pkg.sv
hw/read_capture.sv
hw/fetch_unit.sv
hw/sequencer.sv
hw/data_port.sv
hw/bf_core.sv
bench/bf_core_checker.sv
bench/bf_core_monitor.sv
bench/tb_bf_core.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_bf_core \
    -f bf_core.f \
    -o tb_bf_core_sim

status=0
./obj_dir/tb_bf_core_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Testbench failed" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation finished without failure"
exit 0
